//--- Makefile
# Verilator flow for the MEM/EX queued latches

VERILATOR  ?= verilator
TOP        ?= tb_mem_ex_queued_latches
FILE_LIST  ?= verilog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard src/*.sv include/*.svh tests/*.sv)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_EXE)

$(SIM_EXE): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# exit status of the simulation is the pass or fail result
run: build
	./$(SIM_EXE)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- include/mem_ex_params.svh
`ifndef MEM_EX_PARAMS_SVH
`define MEM_EX_PARAMS_SVH

// modifiable field width, operand values and wake bits
`define MEM_EX_M_WIDTH 16

// fixed field width, decoded control
`define MEM_EX_N_WIDTH 24

// queue depth, must stay a power of two
`define MEM_EX_Q_LENGTH 8

`endif

//--- src/fixed_field_bank.sv
`timescale 1ns/1ps

module fixed_field_bank (
    input  logic                clk,
    input  logic                wr_en,
    input  mem_ex_pkg::q_ptr_t  wr_slot,
    input  mem_ex_pkg::n_word_t n_din,
    input  mem_ex_pkg::q_ptr_t  rd_slot,
    output mem_ex_pkg::n_word_t head_n
);

    import mem_ex_pkg::*;

    // decoded control per slot
    n_word_t slots [Q_LENGTH];

    // written once on push, then held until the slot is reused
    // no forwarding path reaches here
    always_ff @(posedge clk) begin
        if (wr_en) begin
            slots[wr_slot] <= n_din;
        end
    end

    // head control word, valid only while the queue is non-empty
    assign head_n = slots[rd_slot];

endmodule

//--- src/mem_ex_pkg.sv
package mem_ex_pkg;

    `include "mem_ex_params.svh"

    localparam int M_WIDTH  = `MEM_EX_M_WIDTH;
    localparam int N_WIDTH  = `MEM_EX_N_WIDTH;
    localparam int Q_LENGTH = `MEM_EX_Q_LENGTH;
    // slot index width, pointers wrap on their own
    localparam int PTR_WIDTH = $clog2(Q_LENGTH);

    typedef logic [M_WIDTH-1:0]          m_word_t;
    typedef logic [N_WIDTH-1:0]          n_word_t;
    // slot i sits at bits i*M_WIDTH upward
    typedef logic [M_WIDTH*Q_LENGTH-1:0] m_vec_t;
    typedef logic [PTR_WIDTH-1:0]        q_ptr_t;
    // one extra bit so a full queue is representable
    typedef logic [PTR_WIDTH:0]          q_cnt_t;
    typedef logic [Q_LENGTH-1:0]         slot_mask_t;

endpackage

//--- src/mem_ex_queued_latches.sv
`timescale 1ns/1ps

module mem_ex_queued_latches (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clr,
    input  logic                   wr,
    input  logic                   rd,
    input  mem_ex_pkg::m_word_t    m_din,
    input  mem_ex_pkg::n_word_t    n_din,
    input  mem_ex_pkg::slot_mask_t modify_vector,
    input  mem_ex_pkg::m_vec_t     new_m_vector,
    output logic                   full,
    output logic                   empty,
    output mem_ex_pkg::m_vec_t     old_m_vector,
    output logic [mem_ex_pkg::M_WIDTH+mem_ex_pkg::N_WIDTH-1:0] dout
);

    import mem_ex_pkg::*;

    logic    wr_en;
    q_ptr_t  wr_slot;
    q_ptr_t  rd_slot;
    m_word_t head_m;
    n_word_t head_n;

    // slot selection shared by both banks
    queue_ctrl queue_ctrl_i (
        .clk     (clk),
        .reset   (reset),
        .clr     (clr),
        .wr      (wr),
        .rd      (rd),
        .wr_en   (wr_en),
        .wr_slot (wr_slot),
        .rd_slot (rd_slot),
        .full    (full),
        .empty   (empty)
    );

    // operand side, open to forwarding
    mod_field_bank mod_field_bank_i (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_slot       (wr_slot),
        .m_din         (m_din),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector),
        .rd_slot       (rd_slot),
        .head_m        (head_m),
        .old_m_vector  (old_m_vector)
    );

    // control side, frozen per entry
    fixed_field_bank fixed_field_bank_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_slot (wr_slot),
        .n_din   (n_din),
        .rd_slot (rd_slot),
        .head_n  (head_n)
    );

    // M word on top, N word below
    assign dout = {head_m, head_n};

endmodule

//--- src/mod_field_bank.sv
`timescale 1ns/1ps

module mod_field_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  mem_ex_pkg::q_ptr_t     wr_slot,
    input  mem_ex_pkg::m_word_t    m_din,
    input  mem_ex_pkg::slot_mask_t modify_vector,
    input  mem_ex_pkg::m_vec_t     new_m_vector,
    input  mem_ex_pkg::q_ptr_t     rd_slot,
    output mem_ex_pkg::m_word_t    head_m,
    output mem_ex_pkg::m_vec_t     old_m_vector
);

    import mem_ex_pkg::*;

    // payload storage, no reset
    m_word_t slots [Q_LENGTH];

    // each slot updates on its own
    // a fresh push beats a forwarded value on the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (wr_en && (wr_slot == q_ptr_t'(i))) begin
                slots[i] <= m_din;
            end else if (modify_vector[i]) begin
                slots[i] <= new_m_vector[i*M_WIDTH +: M_WIDTH];
            end
        end
    end

    // every slot exposed flat for forwarding
    always_comb begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            old_m_vector[i*M_WIDTH +: M_WIDTH] = slots[i];
        end
    end

    // head word for the execute stage
    assign head_m = slots[rd_slot];

    // forwarding logic must always drive a defined mask
    modify_known_a : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(modify_vector)
    );

endmodule

//--- src/queue_ctrl.sv
`timescale 1ns/1ps

module queue_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               clr,
    input  logic               wr,
    input  logic               rd,
    output logic               wr_en,
    output mem_ex_pkg::q_ptr_t wr_slot,
    output mem_ex_pkg::q_ptr_t rd_slot,
    output logic               full,
    output logic               empty
);

    import mem_ex_pkg::*;

    q_ptr_t wr_ptr;
    q_ptr_t rd_ptr;
    q_cnt_t count;
    q_cnt_t count_next;
    logic   rd_en;

    // strobes only count when the queue can take them
    // clr wins over both
    assign wr_en = wr && !full && !clr;
    assign rd_en = rd && !empty && !clr;

    // banks write at the tail and show the head
    assign wr_slot = wr_ptr;
    assign rd_slot = rd_ptr;

    // push and pop together leave the count alone
    always_comb begin
        count_next = count;
        case ({wr_en, rd_en})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            // power of two depth, so plain increment wraps
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // flags follow the count of the coming cycle
            full  <= (count_next == q_cnt_t'(Q_LENGTH));
            empty <= (count_next == '0);
        end
    end

    // flags are exclusive at any depth above zero
    flags_exclusive_a : assert property (
        @(posedge clk) disable iff (reset)
        !(full && empty)
    );

    // occupancy never runs past the slot count
    count_bound_a : assert property (
        @(posedge clk) disable iff (reset)
        count <= q_cnt_t'(Q_LENGTH)
    );

    // pointer gap matches occupancy, modulo depth
    ptr_gap_a : assert property (
        @(posedge clk) disable iff (reset)
        q_ptr_t'(wr_ptr - rd_ptr) == q_ptr_t'(count)
    );

endmodule

//--- tests/tb_mem_ex_queued_latches.sv
`timescale 1ns/1ps

`include "mem_ex_params.svh"

module tb_mem_ex_queued_latches;

    import mem_ex_pkg::*;

    localparam int MW = `MEM_EX_M_WIDTH;
    localparam int NW = `MEM_EX_N_WIDTH;
    localparam int QL = `MEM_EX_Q_LENGTH;

    logic       clk;
    logic       reset;
    logic       clr;
    logic       wr;
    logic       rd;
    m_word_t    m_din;
    n_word_t    n_din;
    slot_mask_t modify_vector;
    m_vec_t     new_m_vector;
    logic       full;
    logic       empty;
    m_vec_t     old_m_vector;
    logic [MW+NW-1:0] dout;

    // reference queue
    logic [MW-1:0] model_m [QL];
    logic [NW-1:0] model_n [QL];
    // slots never written hold unknown data
    bit            m_known [QL];
    int            head;
    int            tail;
    int            count;

    mem_ex_queued_latches mem_ex_queued_latches_i (
        .clk           (clk),
        .reset         (reset),
        .clr           (clr),
        .wr            (wr),
        .rd            (rd),
        .m_din         (m_din),
        .n_din         (n_din),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "run stopped");
        end
    endtask

    // apply one edge to the model, same priority as the queue rules
    task automatic model_edge();
        bit wr_ok;
        bit rd_ok;
        wr_ok = wr && (count < QL) && !clr;
        rd_ok = rd && (count > 0) && !clr;
        // m_din beats a modify on the tail slot
        for (int i = 0; i < QL; i++) begin
            if (wr_ok && (i == tail)) begin
                model_m[i] = m_din;
                m_known[i] = 1'b1;
            end else if (modify_vector[i]) begin
                model_m[i] = new_m_vector[i*MW +: MW];
                m_known[i] = 1'b1;
            end
        end
        if (wr_ok) begin
            model_n[tail] = n_din;
        end
        if (clr) begin
            head  = 0;
            tail  = 0;
            count = 0;
        end else begin
            if (wr_ok) begin
                tail = (tail + 1) % QL;
            end
            if (rd_ok) begin
                head = (head + 1) % QL;
            end
            count = count + int'(wr_ok) - int'(rd_ok);
        end
    endtask

    task automatic check_outputs();
        check_value("empty flag", 64'(count == 0), 64'(empty));
        check_value("full flag", 64'(count == QL), 64'(full));
        // dout only means something with entries queued
        if (count != 0) begin
            check_value("dout head entry", 64'({model_m[head], model_n[head]}), 64'(dout));
        end
        for (int i = 0; i < QL; i++) begin
            if (m_known[i]) begin
                check_value($sformatf("old_m_vector slot %0d", i), 64'(model_m[i]),
                            64'(old_m_vector[i*MW +: MW]));
            end
        end
    endtask

    // one clock, called and returning on a falling edge
    task automatic cycle();
        @(posedge clk);
        model_edge();
        @(negedge clk);
        check_outputs();
    endtask

    // quiet strobes, fresh random payload
    task automatic drive_idle();
        wr            = 1'b0;
        rd            = 1'b0;
        clr           = 1'b0;
        modify_vector = '0;
        new_m_vector  = '0;
        m_din         = MW'($urandom);
        n_din         = NW'($urandom);
    endtask

    // sparse forwarding mask, roughly one slot in four
    task automatic random_modify();
        for (int i = 0; i < QL; i++) begin
            modify_vector[i]          = ($urandom_range(0, 3) == 0);
            new_m_vector[i*MW +: MW]  = MW'($urandom);
        end
    endtask

    task automatic fill_until_full();
        int waited;
        waited = 0;
        while (!full) begin
            if (waited > QL + 4) begin
                abort_run("timeout: queue never reported full while pushing");
            end else begin
                drive_idle();
                wr = 1'b1;
                cycle();
                waited++;
            end
        end
    endtask

    task automatic drain_until_empty();
        int waited;
        waited = 0;
        while (!empty) begin
            if (waited > QL + 4) begin
                abort_run("timeout: queue never reported empty while popping");
            end else begin
                drive_idle();
                rd = 1'b1;
                cycle();
                waited++;
            end
        end
    endtask

    initial begin
        logic [MW-1:0] pushed_m;
        int            hit_slot;
        void'($urandom(74));
        head  = 0;
        tail  = 0;
        count = 0;
        for (int i = 0; i < QL; i++) begin
            m_known[i] = 1'b0;
        end
        reset = 1'b1;
        drive_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_outputs();

        // pops on an empty queue do nothing
        repeat (3) begin
            drive_idle();
            rd = 1'b1;
            cycle();
        end

        // plain push and pop traffic, FIFO order through dout
        repeat (400) begin
            drive_idle();
            wr = ($urandom_range(0, 99) < 55);
            rd = ($urandom_range(0, 99) < 45);
            cycle();
        end

        // full queue drops writes, alone or paired with a pop
        fill_until_full();
        repeat (2) begin
            drive_idle();
            wr = 1'b1;
            cycle();
        end
        drive_idle();
        wr = 1'b1;
        rd = 1'b1;
        cycle();
        drain_until_empty();

        // traffic with forwarding and the odd clear
        repeat (1500) begin
            drive_idle();
            wr  = ($urandom_range(0, 99) < 50);
            rd  = ($urandom_range(0, 99) < 45);
            clr = ($urandom_range(0, 99) == 0);
            random_modify();
            cycle();
        end

        // clear in the middle of a push and pop
        repeat (5) begin
            drive_idle();
            wr = 1'b1;
            cycle();
        end
        drive_idle();
        wr  = 1'b1;
        rd  = 1'b1;
        clr = 1'b1;
        cycle();

        // push and forward onto the same slot
        drive_idle();
        wr       = 1'b1;
        hit_slot = tail;
        pushed_m = m_din;
        modify_vector[hit_slot]            = 1'b1;
        new_m_vector[hit_slot*MW +: MW]    = ~m_din;
        cycle();
        check_value("push beats modify", 64'(pushed_m),
                    64'(old_m_vector[hit_slot*MW +: MW]));

        // order holds after the clear
        repeat (200) begin
            drive_idle();
            wr = ($urandom_range(0, 99) < 55);
            rd = ($urandom_range(0, 99) < 45);
            random_modify();
            cycle();
        end
        drain_until_empty();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
src/mem_ex_pkg.sv
src/queue_ctrl.sv
src/mod_field_bank.sv
src/fixed_field_bank.sv
src/mem_ex_queued_latches.sv
tests/tb_mem_ex_queued_latches.sv
